// ==== Makefile ====
# Verilator build and run for the tag directory testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tag_directory_tb
FILELIST  ?= cache_refill.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Log is searched for the pass line, grep sets the exit status
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cache_refill.f ====
source/refill_pkg.sv
source/lfsr_16bit.sv
source/tag_store.sv
source/way_select.sv
source/tag_directory.sv
tb/tb_clock_gen.sv
tb/tag_directory_tb.sv

// ==== source/lfsr_16bit.sv ====
/* Sixteen-bit LFSR giving a pseudo-random victim way,
   one-hot and binary, advanced on an enable */

`timescale 1ns/1ps

module lfsr_16bit import refill_pkg::*; #(
    parameter logic [15:0] Seed    = LfsrSeedDefault,
    parameter int unsigned NumWays = NumWaysDefault
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       en_i,
    output logic [NumWays-1:0]         refill_way_oh,
    output logic [$clog2(NumWays)-1:0] refill_way_bin
);

    localparam int unsigned LogWays = $clog2(NumWays);

    logic [15:0] state_d, state_q;
    logic        feedback;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------

    // Inverted XOR of the taps, so all zeros is a legal state
    assign feedback = ~(state_q[15] ^ state_q[12] ^ state_q[5] ^ state_q[1]);

    // Shift left, new bit enters at the bottom
    assign state_d = en_i ? {state_q[14:0], feedback} : state_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= Seed;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------
    // Way outputs
    // ------------------------------------------------------------

    // Low state bits name the random way
    assign refill_way_bin = state_q[LogWays-1:0];

    // Same way as a one-hot vector
    always_comb begin
        refill_way_oh = '0;
        refill_way_oh[state_q[LogWays-1:0]] = 1'b1;
    end

    // Way count must fit the state and decode fully
    assert property (@(posedge clk_i) (NumWays <= 16) && ((1 << LogWays) == NumWays))
        else $error("lfsr_16bit supports a power-of-two way count up to 16");

endmodule : lfsr_16bit

// ==== source/refill_pkg.sv ====
/* Default cache geometry, LFSR seed and address field widths
   shared by the tag directory RTL and its testbench */

package refill_pkg;

    // ------------------------------------------------------------
    // Address layout
    // ------------------------------------------------------------

    // Full lookup address, one word
    localparam int unsigned AddrWidth = 32;

    // Byte offset inside a line, 16-byte lines
    localparam int unsigned OffsetWidth = 4;

    // ------------------------------------------------------------
    // Default geometry
    // ------------------------------------------------------------

    // Sets in the directory
    localparam int unsigned NumSetsDefault = 16;

    // Ways per set, power of two and at most 16
    localparam int unsigned NumWaysDefault = 4;

    // ------------------------------------------------------------
    // Replacement
    // ------------------------------------------------------------

    // Reset state of the victim LFSR, must not be all ones
    localparam logic [15:0] LfsrSeedDefault = 16'h00A5;

endpackage : refill_pkg

// ==== source/tag_directory.sv ====
/* Tag directory top level, address split, allocation write,
   LFSR step and the registered one-cycle response */

`timescale 1ns/1ps

module tag_directory import refill_pkg::*; #(
    parameter int unsigned NumSets = NumSetsDefault,
    parameter int unsigned NumWays = NumWaysDefault,
    parameter logic [15:0] Seed    = LfsrSeedDefault
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       req_i,
    input  logic [AddrWidth-1:0]       addr_i,
    input  logic                       flush_i,
    output logic                       resp_valid_o,
    output logic                       hit_o,
    output logic [$clog2(NumWays)-1:0] way_o
);

    localparam int unsigned IndexWidth = $clog2(NumSets);
    localparam int unsigned TagWidth   = AddrWidth - OffsetWidth - IndexWidth;
    localparam int unsigned WayWidth   = $clog2(NumWays);

    // Address fields
    logic [IndexWidth-1:0] index;
    logic [TagWidth-1:0]   tag;

    // Indexed set as read from the store
    logic [NumWays-1:0][TagWidth-1:0] set_tags;
    logic [NumWays-1:0]               set_valid;

    // Selector results
    logic                hit, use_random;
    logic [WayWidth-1:0] hit_way, victim_way;

    // LFSR interface
    logic                lfsr_en;
    logic [WayWidth-1:0] lfsr_way_bin;

    // Request accepted this cycle, and the allocation it causes
    logic req_valid;
    logic wr_en;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------

    assign index = addr_i[OffsetWidth +: IndexWidth];
    assign tag   = addr_i[AddrWidth-1 -: TagWidth];

    // Flush wins, a coincident request is dropped
    assign req_valid = req_i & ~flush_i;

    // Miss allocates right away, LFSR steps only on a full set
    assign wr_en   = req_valid & ~hit;
    assign lfsr_en = wr_en & use_random;

    tag_store #(
        .NumSets (NumSets),
        .NumWays (NumWays)
    ) tag_store_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .flush_i  (flush_i),
        .rd_index (index),
        .rd_tags  (set_tags),
        .rd_valid (set_valid),
        .wr_en    (wr_en),
        .wr_index (index),
        .wr_way   (victim_way),
        .wr_tag   (tag)
    );

    way_select #(
        .NumSets (NumSets),
        .NumWays (NumWays)
    ) way_select_i (
        .tag        (tag),
        .set_tags   (set_tags),
        .set_valid  (set_valid),
        .random_way (lfsr_way_bin),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .use_random (use_random)
    );

    lfsr_16bit #(
        .Seed    (Seed),
        .NumWays (NumWays)
    ) lfsr_16bit_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .en_i           (lfsr_en),
        .refill_way_oh  (),
        .refill_way_bin (lfsr_way_bin)
    );

    // ------------------------------------------------------------
    // Response register
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= req_valid;
        end
    end

    // Hit way on a hit, else the way just allocated
    always_ff @(posedge clk_i) begin
        if (req_valid) begin
            hit_o <= hit;
            way_o <= hit ? hit_way : victim_way;
        end
    end

endmodule : tag_directory

// ==== source/tag_store.sv ====
/* Tag and valid storage per set and way, whole-set read,
   single-way write and a flush of all valid bits */

`timescale 1ns/1ps

module tag_store import refill_pkg::*; #(
    parameter int unsigned NumSets = NumSetsDefault,
    parameter int unsigned NumWays = NumWaysDefault
) (
    input  logic                                                    clk_i,
    input  logic                                                    rst_ni,
    input  logic                                                    flush_i,
    // Whole-set read port
    input  logic [$clog2(NumSets)-1:0]                              rd_index,
    output logic [NumWays-1:0][AddrWidth-OffsetWidth-$clog2(NumSets)-1:0] rd_tags,
    output logic [NumWays-1:0]                                      rd_valid,
    // Single-way write port
    input  logic                                                    wr_en,
    input  logic [$clog2(NumSets)-1:0]                              wr_index,
    input  logic [$clog2(NumWays)-1:0]                              wr_way,
    input  logic [AddrWidth-OffsetWidth-$clog2(NumSets)-1:0]        wr_tag
);

    localparam int unsigned IndexWidth = $clog2(NumSets);
    localparam int unsigned TagWidth   = AddrWidth - OffsetWidth - IndexWidth;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    // Tag array, one entry per set and way
    logic [NumWays-1:0][TagWidth-1:0] tag_q [NumSets];

    // Valid bits, cleared by reset and flush
    logic [NumSets-1:0][NumWays-1:0] valid_d, valid_q;

    // Decoded write way
    logic [NumWays-1:0] wr_way_oh;

    // ------------------------------------------------------------
    // Read
    // ------------------------------------------------------------

    // Whole set is visible in the same cycle
    assign rd_tags  = tag_q[rd_index];
    assign rd_valid = valid_q[rd_index];

    // ------------------------------------------------------------
    // Write
    // ------------------------------------------------------------

    always_comb begin
        wr_way_oh = '0;
        wr_way_oh[wr_way] = 1'b1;
    end

    // Flush takes priority over any allocation
    always_comb begin
        valid_d = valid_q;
        if (flush_i) begin
            valid_d = '0;
        end else if (wr_en) begin
            valid_d[wr_index] = valid_q[wr_index] | wr_way_oh;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Tags only matter once marked valid
    always_ff @(posedge clk_i) begin
        if (wr_en && !flush_i) begin
            tag_q[wr_index][wr_way] <= wr_tag;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    // Top level drops requests that coincide with a flush
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(wr_en && flush_i))
        else $error("tag_store: allocation write during flush");

endmodule : tag_store

// ==== source/way_select.sv ====
/* Tag compare over one set, binary hit way, and victim choice
   between the lowest invalid way and the LFSR way */

`timescale 1ns/1ps

module way_select import refill_pkg::*; #(
    parameter int unsigned NumSets = NumSetsDefault,
    parameter int unsigned NumWays = NumWaysDefault
) (
    input  logic [AddrWidth-OffsetWidth-$clog2(NumSets)-1:0]              tag,
    input  logic [NumWays-1:0][AddrWidth-OffsetWidth-$clog2(NumSets)-1:0] set_tags,
    input  logic [NumWays-1:0]                                            set_valid,
    input  logic [$clog2(NumWays)-1:0]                                    random_way,
    output logic                                                          hit,
    output logic [$clog2(NumWays)-1:0]                                    hit_way,
    output logic [$clog2(NumWays)-1:0]                                    victim_way,
    output logic                                                          use_random
);

    localparam int unsigned TagWidth = AddrWidth - OffsetWidth - $clog2(NumSets);
    localparam int unsigned WayWidth = $clog2(NumWays);

    // Per-way match, only valid ways count
    logic [NumWays-1:0] match;

    // Lowest invalid way and whether one exists
    logic [WayWidth-1:0] free_way;
    logic                free_found;

    // ------------------------------------------------------------
    // Hit detection
    // ------------------------------------------------------------

    always_comb begin
        for (int w = 0; w < NumWays; w++) begin
            match[w] = set_valid[w] && (set_tags[w] == TagWidth'(tag));
        end
    end

    assign hit = |match;

    // Binary encode of the matching way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NumWays; w++) begin
            if (match[w]) begin
                hit_way = WayWidth'(w);
            end
        end
    end

    // ------------------------------------------------------------
    // Victim choice
    // ------------------------------------------------------------

    // Scan upward, first hole wins
    always_comb begin
        free_way   = '0;
        free_found = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            if (!set_valid[w] && !free_found) begin
                free_way   = WayWidth'(w);
                free_found = 1'b1;
            end
        end
    end

    // Full set falls back to the LFSR
    assign use_random = ~free_found;
    assign victim_way = use_random ? random_way : free_way;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    // Allocation only on a miss keeps tags unique within a set
    always_comb begin
        assert final ($onehot0(match))
            else $error("way_select: tag matches more than one way");
    end

endmodule : way_select

// ==== tb/tag_directory_tb.sv ====
/* Directed tests for the tag directory with a reference model of
   tags, valid bits and the victim LFSR, compare tasks and a watchdog */

`timescale 1ns/1ps

module tag_directory_tb import refill_pkg::*; ();

    localparam int unsigned NumSets    = NumSetsDefault;
    localparam int unsigned NumWays    = NumWaysDefault;
    localparam int unsigned IndexWidth = $clog2(NumSets);
    localparam int unsigned TagWidth   = AddrWidth - OffsetWidth - IndexWidth;
    localparam int unsigned WayWidth   = $clog2(NumWays);

    // Reset plus the five tests, set filling dominates test 3
    localparam int TestCycles    = 6 + 6 + 12 + 90 + 10 + 10;
    localparam int TimeoutCycles = 2 * TestCycles;

    logic                 clk;
    logic                 rst_n;
    logic                 req;
    logic [AddrWidth-1:0] addr;
    logic                 flush;
    logic                 resp_valid;
    logic                 hit;
    logic [WayWidth-1:0]  way;

    // Reference model state
    logic [TagWidth-1:0] model_tag [NumSets][NumWays];
    logic [NumWays-1:0]  model_valid [NumSets];
    logic [15:0]         model_lfsr;
    logic [31:0]         rand_state;

    int                   errors;
    int                   checks;
    int                   cycle_count;
    logic [AddrWidth-1:0] fill_addr [4];
    logic [AddrWidth-1:0] first_addr;

    tb_clock_gen #(
        .PeriodNs    (10),
        .ResetCycles (5)
    ) tb_clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tag_directory #(
        .NumSets (NumSets),
        .NumWays (NumWays),
        .Seed    (LfsrSeedDefault)
    ) tag_directory_i (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .req_i        (req),
        .addr_i       (addr),
        .flush_i      (flush),
        .resp_valid_o (resp_valid),
        .hit_o        (hit),
        .way_o        (way)
    );

    // ------------------------------------------------------------
    // Model helpers
    // ------------------------------------------------------------

    function automatic logic [IndexWidth-1:0] index_of(input logic [AddrWidth-1:0] a);
        return a[OffsetWidth +: IndexWidth];
    endfunction

    function automatic logic [TagWidth-1:0] tag_of(input logic [AddrWidth-1:0] a);
        return a[AddrWidth-1 -: TagWidth];
    endfunction

    // Inverted XOR of taps 15, 12, 5, 1 shifted in at bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = ~(s[15] ^ s[12] ^ s[5] ^ s[1]);
        return {s[14:0], fb};
    endfunction

    // Linear congruential generator, 32-bit wrap
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic logic model_holds(input logic [AddrWidth-1:0] a);
        logic found;
        found = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            if (model_valid[index_of(a)][w] && model_tag[index_of(a)][w] == tag_of(a)) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Lookup and allocation as the directory should do it
    task automatic model_access(input logic [AddrWidth-1:0] a, output logic exp_hit,
                                output logic [WayWidth-1:0] exp_way);
        logic [IndexWidth-1:0] idx;
        logic                  free_found;
        idx        = index_of(a);
        exp_hit    = 1'b0;
        exp_way    = '0;
        free_found = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag_of(a)) begin
                exp_hit = 1'b1;
                exp_way = WayWidth'(w);
            end
        end
        if (!exp_hit) begin
            // Lowest invalid way first
            for (int w = 0; w < NumWays; w++) begin
                if (!model_valid[idx][w] && !free_found) begin
                    exp_way    = WayWidth'(w);
                    free_found = 1'b1;
                end
            end
            // Full set, LFSR picks and then steps
            if (!free_found) begin
                exp_way    = model_lfsr[WayWidth-1:0];
                model_lfsr = lfsr_step(model_lfsr);
            end
            model_tag[idx][exp_way]   = tag_of(a);
            model_valid[idx][exp_way] = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------

    task automatic check_hit(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] hit_o: got 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_way(input logic [WayWidth-1:0] got, input logic [WayWidth-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] way_o: got 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] resp_valid_o: got 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------

    // One-cycle strobe, returns 1 ns after the edge that registers the response
    task automatic drive_request(input logic [AddrWidth-1:0] a);
        req  = 1'b1;
        addr = a;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    // Expected result from the model
    task automatic lookup(input logic [AddrWidth-1:0] a);
        logic                exp_hit;
        logic [WayWidth-1:0] exp_way;
        model_access(a, exp_hit, exp_way);
        drive_request(a);
        check_valid(resp_valid, 1'b1);
        check_hit(hit, exp_hit);
        check_way(way, exp_way);
    endtask

    // Expected result given by the test, model still kept in step
    task automatic lookup_expect(input logic [AddrWidth-1:0] a, input logic exp_hit,
                                 input logic [WayWidth-1:0] exp_way);
        logic                model_hit;
        logic [WayWidth-1:0] model_way;
        model_access(a, model_hit, model_way);
        drive_request(a);
        check_valid(resp_valid, 1'b1);
        check_hit(hit, exp_hit);
        check_way(way, exp_way);
    endtask

    // Flush, optionally with a request that must be dropped
    task automatic flush_dir(input logic with_req, input logic [AddrWidth-1:0] a);
        flush = 1'b1;
        req   = with_req;
        addr  = a;
        for (int s = 0; s < NumSets; s++) begin
            model_valid[s] = '0;
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
        req   = 1'b0;
        check_valid(resp_valid, 1'b0);
    endtask

    task automatic idle_check(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            check_valid(resp_valid, 1'b0);
        end
    endtask

    task automatic report_test(input string name, input int e0, input int c0);
        $display("%-24s %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------

    task automatic test_first_miss();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        idle_check(3);
        // Tag 1, set 3
        first_addr = 32'h0000_0130;
        lookup_expect(first_addr, 1'b0, '0);
        idle_check(1);
        report_test("first_miss", e0, c0);
    endtask

    task automatic test_fill_and_hit();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        // Four tags in set 5, offsets differ and must not matter
        for (int k = 0; k < 4; k++) begin
            fill_addr[k] = {TagWidth'(k + 16), IndexWidth'(5), OffsetWidth'(4 * k)};
        end
        for (int k = 0; k < 4; k++) begin
            lookup_expect(fill_addr[k], 1'b0, WayWidth'(k));
        end
        for (int k = 0; k < 4; k++) begin
            lookup_expect(fill_addr[k], 1'b1, WayWidth'(k));
        end
        idle_check(1);
        report_test("fill_and_hit", e0, c0);
    endtask

    task automatic test_random_replacement();
        logic [AddrWidth-1:0]  a;
        logic [IndexWidth-1:0] idx;
        int                    e0;
        int                    c0;
        e0 = errors;
        c0 = checks;
        for (int n = 0; n < 20; n++) begin
            idx = index_of(next_rand());
            // Top up the set until every way is valid
            while (model_valid[idx] != '1) begin
                a = next_rand();
                a[OffsetWidth +: IndexWidth] = idx;
                lookup(a);
            end
            // Fresh tag for a guaranteed full-set miss
            do begin
                a = next_rand();
                a[OffsetWidth +: IndexWidth] = idx;
            end while (model_holds(a));
            lookup(a);
        end
        idle_check(1);
        report_test("random_replacement", e0, c0);
    endtask

    task automatic test_back_to_back();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        flush_dir(1'b0, '0);
        // Same address twice, second sees the first allocation
        lookup_expect({TagWidth'('h5A5A5), IndexWidth'(9), OffsetWidth'(0)}, 1'b0, '0);
        lookup_expect({TagWidth'('h5A5A5), IndexWidth'(9), OffsetWidth'(0)}, 1'b1, '0);
        for (int k = 1; k < 4; k++) begin
            lookup_expect({TagWidth'('h5A5A5 + k), IndexWidth'(9), OffsetWidth'(0)},
                          1'b0, WayWidth'(k));
        end
        // Victim here shows whether the fills above moved the LFSR
        lookup({TagWidth'('h5A5A5 + 4), IndexWidth'(9), OffsetWidth'(0)});
        idle_check(1);
        report_test("back_to_back", e0, c0);
    endtask

    task automatic test_flush();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        flush_dir(1'b1, fill_addr[0]);
        // Dropped request allocated nothing, so set 5 refills from way 0
        for (int k = 0; k < 4; k++) begin
            lookup_expect(fill_addr[k], 1'b0, WayWidth'(k));
        end
        lookup_expect(first_addr, 1'b0, '0);
        idle_check(1);
        report_test("flush", e0, c0);
    endtask

    // ------------------------------------------------------------
    // Sequence and watchdog
    // ------------------------------------------------------------

    initial begin : main
        req        = 1'b0;
        addr       = '0;
        flush      = 1'b0;
        errors     = 0;
        checks     = 0;
        rand_state = 32'd26;
        model_lfsr = LfsrSeedDefault;
        for (int s = 0; s < NumSets; s++) begin
            model_valid[s] = '0;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        test_first_miss();
        test_fill_and_hit();
        test_random_replacement();
        test_back_to_back();
        test_flush();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TimeoutCycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        $display("Test failed");
        $finish;
    end

endmodule : tag_directory_tb

// ==== tb/tb_clock_gen.sv ====
/* Testbench clock source and power-on reset */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PeriodNs    = 10,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Reset low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule : tb_clock_gen
